// File: verilog.f
src/tetris_pkg.sv
src/game_ctrl.sv
src/column_height.sv
src/drop_solver.sv
src/board_store.sv
src/tetris_top.sv
testbench/tetris_checker.sv
testbench/score_monitor.sv
testbench/tb_tetris.sv

// File: Makefile
# Verilator build of the stacking game testbench
# override on the command line, e.g. make run BUILD_DIR=build LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_tetris
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tetris_testdata.txt
// digits: shape, column, expected score, expected fail, expected board (18 hex)
// board is nonzero only on a game's last piece, F in the shape digit ends the list
// game 1, two clears then a bar stack that overflows on piece 9
2000000000000000000000
0410000000000000000000
1010000000000000000000
5110000000000000000000
1320000000000000000000
1520000000000000000000
1020000000000000000000
1020000000000000000000
1021041041041041869AEB
// game 2, sixteen pieces with a double clear on piece 3
2000000000000000000000
2000000000000000000000
0420000000000000000000
7020000000000000000000
4320000000000000000000
1030000000000000000000
5430000000000000000000
6140000000000000000000
1540000000000000000000
3250000000000000000000
1250000000000000000000
0050000000000000000000
0360000000000000000000
1570000000000000000000
2070000000000000000000
1480000000000000D34F7B
// game 3, fresh board after the game over
0200000000000000000000
3000000000000000000000
F000000000000000000000

// File: testbench/tb_tetris.sv
// --------------------------------------------------------------------------
// testbench top of the stacking game engine
// clock, reset, data file reading and piece driving
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_tetris import tetris_pkg::*; ();

    localparam int MAX_LINES = 64;
    localparam int TIMEOUT   = 50;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    shape_t tetrominoes;
    col_t   position;
    logic   score_valid;
    score_t score;
    logic   fail;
    logic   tetris_valid;
    board_t tetris;

    // one vector per piece, see the data file for the digit layout
    logic [87:0] vectors [0:MAX_LINES-1];

    score_t exp_score;
    logic   exp_fail;
    logic   exp_end;
    board_t exp_board;
    int     piece_idx;
    int     err_count;
    int     pass_count;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    tetris_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .tetrominoes  (tetrominoes),
        .position     (position),
        .score_valid  (score_valid),
        .score        (score),
        .fail         (fail),
        .tetris_valid (tetris_valid),
        .tetris       (tetris)
    );

    score_monitor u_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .score_valid  (score_valid),
        .score        (score),
        .fail         (fail),
        .tetris_valid (tetris_valid),
        .tetris       (tetris),
        .exp_score    (exp_score),
        .exp_fail     (exp_fail),
        .exp_end      (exp_end),
        .exp_board    (exp_board),
        .piece_idx    (piece_idx),
        .err_count    (err_count),
        .pass_count   (pass_count)
    );

    bind tetris_top tetris_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .score_valid  (score_valid),
        .fail         (fail),
        .tetris_valid (tetris_valid),
        .accept       (accept),
        .phase        (phase)
    );

    // poll for the result pulse, gives up after TIMEOUT cycles
    task automatic wait_result(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            if (score_valid)
                seen = 1'b1;
            cycles++;
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        int          n;
        int          game_pieces;
        int          gap;
        int          seed_ret;
        logic        seen;
        logic        ends;
        logic        timed_out;
        logic [87:0] v;
        seed_ret    = $urandom(26944);
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        tetrominoes = '0;
        position    = '0;
        exp_score   = '0;
        exp_fail    = 1'b0;
        exp_end     = 1'b0;
        exp_board   = '0;
        piece_idx   = 0;
        timed_out   = 1'b0;
        $readmemh("testbench/tetris_testdata.txt", vectors);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // idle cycles, monitor expects all outputs at zero
        repeat (3) @(posedge clk);
        n           = 0;
        game_pieces = 0;
        while (!timed_out && n < MAX_LINES && vectors[n][87:84] != 4'hF) begin
            v   = vectors[n];
            gap = $urandom % 6;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            game_pieces++;
            // game ends on a fail or on its 16th piece
            ends = v[72] || (game_pieces == 16);
            in_valid    <= 1'b1;
            tetrominoes <= v[86:84];
            position    <= v[82:80];
            exp_score   <= v[79:76];
            exp_fail    <= v[72];
            exp_end     <= ends;
            exp_board   <= v[71:0];
            piece_idx   <= n + 1;
            @(posedge clk);
            in_valid <= 1'b0;
            wait_result(seen);
            if (!seen) begin
                $display("no score_valid within %0d cycles for piece %0d", TIMEOUT, n + 1);
                timed_out = 1'b1;
            end else begin
                if (ends)
                    game_pieces = 0;
                n++;
            end
        end
        repeat (3) @(posedge clk);
        $display("pieces %0d, passed %0d, failed checks %0d", n, pass_count, err_count);
        if (!timed_out && err_count == 0 && n > 0 && pass_count == n)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/score_monitor.sv
// --------------------------------------------------------------------------
// result monitor of the game engine testbench
// compares each score_valid pulse with the expected values
// flags any result output that is active outside the result cycle
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module score_monitor import tetris_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   score_valid,
    input  score_t score,
    input  logic   fail,
    input  logic   tetris_valid,
    input  board_t tetris,
    input  score_t exp_score,
    input  logic   exp_fail,
    input  logic   exp_end,
    input  board_t exp_board,
    input  int     piece_idx,
    output int     err_count,
    output int     pass_count
);

    int errs  = 0;
    int goods = 0;

    assign err_count  = errs;
    assign pass_count = goods;

    // sample mid-cycle, outputs settle after the rising edge
    always @(negedge clk) begin
        logic bad;
        bad = 1'b0;
        if (rst_n && score_valid) begin
            if (score !== exp_score) begin
                $display("[FAIL] piece %0d score: got %h, expected %h", piece_idx, score,
                         exp_score);
                bad = 1'b1;
            end
            if (fail !== exp_fail) begin
                $display("[FAIL] piece %0d fail: got %h, expected %h", piece_idx, fail,
                         exp_fail);
                bad = 1'b1;
            end
            if (tetris_valid !== exp_end) begin
                $display("[FAIL] piece %0d tetris_valid: got %h, expected %h", piece_idx,
                         tetris_valid, exp_end);
                bad = 1'b1;
            end
            // board is zero unless the game ends
            if (tetris !== exp_board) begin
                $display("[FAIL] piece %0d tetris: got %h, expected %h", piece_idx, tetris,
                         exp_board);
                bad = 1'b1;
            end
            if (bad) begin
                errs++;
                $display("piece %0d: mismatch", piece_idx);
            end else begin
                goods++;
                $display("piece %0d: ok, score %h", piece_idx, score);
            end
        end else if (rst_n) begin
            if (score !== '0 || fail !== 1'b0 || tetris_valid !== 1'b0 || tetris !== '0) begin
                $display("result outputs are active outside the result cycle at %0t", $time);
                errs++;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tetris_checker.sv
// --------------------------------------------------------------------------
// concurrent assertions on the result protocol of the game engine
// bound into the top level
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tetris_checker import tetris_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        score_valid,
    input logic        fail,
    input logic        tetris_valid,
    input logic        accept,
    input game_state_t phase
);

    // result is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        score_valid |=> !score_valid)
        else $error("score_valid high for more than one cycle");

    // a failed game always reports its board
    a_fail_board: assert property (@(posedge clk) disable iff (!rst_n)
        fail |-> tetris_valid)
        else $error("fail without tetris_valid");

    a_board_in_result: assert property (@(posedge clk) disable iff (!rst_n)
        tetris_valid |-> score_valid)
        else $error("tetris_valid outside the result cycle");

    // placement starts only from a piece taken in while idle
    a_accept_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == st_place) |-> $past(accept && (phase == st_idle)))
        else $error("piece placed without an accept in idle");

endmodule

`default_nettype wire

// File: src/tetris_top.sv
// --------------------------------------------------------------------------
// top level of the stacking game engine
// FSM plus height, landing and board datapath
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tetris_top import tetris_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  shape_t tetrominoes,
    input  col_t   position,
    output logic   score_valid,
    output score_t score,
    output logic   fail,
    output logic   tetris_valid,
    output board_t tetris
);

    // control to datapath
    logic        accept;
    game_state_t phase;
    // board and its flags
    ext_board_t  board_ext;
    board_t      board_vis;
    logic        row_full_any;
    logic        overflow;
    // landing path
    heights_t    heights;
    row_t        land_row;
    shape_t      shape_q;
    col_t        col_q;

    game_ctrl u_game_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .row_full_any (row_full_any),
        .overflow     (overflow),
        .board_vis    (board_vis),
        .accept       (accept),
        .phase        (phase),
        .score_valid  (score_valid),
        .tetris_valid (tetris_valid),
        .fail         (fail),
        .score        (score),
        .tetris       (tetris)
    );

    column_height u_column_height (
        .board_ext (board_ext),
        .heights   (heights)
    );

    drop_solver u_drop_solver (
        .clk         (clk),
        .rst_n       (rst_n),
        .accept      (accept),
        .tetrominoes (tetrominoes),
        .position    (position),
        .heights     (heights),
        .land_row    (land_row),
        .shape_q     (shape_q),
        .col_q       (col_q)
    );

    board_store u_board_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .phase        (phase),
        .land_row     (land_row),
        .shape_q      (shape_q),
        .col_q        (col_q),
        .board_ext    (board_ext),
        .board_vis    (board_vis),
        .row_full_any (row_full_any),
        .overflow     (overflow)
    );

endmodule

`default_nettype wire

// File: src/board_store.sv
// --------------------------------------------------------------------------
// board register with four overflow rows
// piece placement, single-row clear, full-row and overflow flags
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module board_store import tetris_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  game_state_t phase,
    input  row_t        land_row,
    input  shape_t      shape_q,
    input  col_t        col_q,
    output ext_board_t  board_ext,
    output board_t      board_vis,
    output logic        row_full_any,
    output logic        overflow
);

    ext_board_t         board_q;
    ext_board_t         board_nxt;
    ext_board_t         piece_mask;
    logic [BOARD_H-1:0] full_now;
    logic [BOARD_H-1:0] full_nxt;
    row_t               clr_row;

    // ----------------------------------------------------------------------
    // four cells of the piece around (land_row, col_q)
    // ----------------------------------------------------------------------
    always_comb begin
        int r0;
        int c0;
        r0 = int'(land_row);
        c0 = int'(col_q);
        piece_mask = '0;
        piece_mask[r0*BOARD_W + c0] = 1'b1;
        case (shape_q)
            SHAPE_SQUARE: begin
                piece_mask[r0*BOARD_W + c0 + 1]     = 1'b1;
                piece_mask[(r0+1)*BOARD_W + c0]     = 1'b1;
                piece_mask[(r0+1)*BOARD_W + c0 + 1] = 1'b1;
            end
            SHAPE_BAR_V: begin
                piece_mask[(r0+1)*BOARD_W + c0] = 1'b1;
                piece_mask[(r0+2)*BOARD_W + c0] = 1'b1;
                piece_mask[(r0+3)*BOARD_W + c0] = 1'b1;
            end
            SHAPE_BAR_H: begin
                piece_mask[r0*BOARD_W + c0 + 1] = 1'b1;
                piece_mask[r0*BOARD_W + c0 + 2] = 1'b1;
                piece_mask[r0*BOARD_W + c0 + 3] = 1'b1;
            end
            // landing row is at least 2 here
            SHAPE_J_UP: begin
                piece_mask[r0*BOARD_W + c0 + 1]     = 1'b1;
                piece_mask[(r0-1)*BOARD_W + c0 + 1] = 1'b1;
                piece_mask[(r0-2)*BOARD_W + c0 + 1] = 1'b1;
            end
            SHAPE_L_FLAT: begin
                piece_mask[(r0+1)*BOARD_W + c0]     = 1'b1;
                piece_mask[(r0+1)*BOARD_W + c0 + 1] = 1'b1;
                piece_mask[(r0+1)*BOARD_W + c0 + 2] = 1'b1;
            end
            SHAPE_L_UP: begin
                piece_mask[(r0+1)*BOARD_W + c0] = 1'b1;
                piece_mask[(r0+2)*BOARD_W + c0] = 1'b1;
                piece_mask[r0*BOARD_W + c0 + 1] = 1'b1;
            end
            SHAPE_S_V: begin
                piece_mask[(r0+1)*BOARD_W + c0]     = 1'b1;
                piece_mask[r0*BOARD_W + c0 + 1]     = 1'b1;
                piece_mask[(r0-1)*BOARD_W + c0 + 1] = 1'b1;
            end
            default: begin
                piece_mask[r0*BOARD_W + c0 + 1]     = 1'b1;
                piece_mask[(r0+1)*BOARD_W + c0 + 1] = 1'b1;
                piece_mask[(r0+1)*BOARD_W + c0 + 2] = 1'b1;
            end
        endcase
    end

    // highest full visible row of the current board
    always_comb begin
        clr_row = '0;
        for (int r = 0; r < BOARD_H; r++) begin
            full_now[r] = &board_q[r*BOARD_W +: BOARD_W];
            if (full_now[r])
                clr_row = row_t'(r);
        end
    end

    // ----------------------------------------------------------------------
    // next board
    // ----------------------------------------------------------------------
    always_comb begin
        board_nxt = board_q;
        case (phase)
            st_place: board_nxt = board_q | piece_mask;
            // drop the row, everything above moves down one
            st_clear: begin
                for (int r = 0; r < BOARD_H_EXT - 1; r++) begin
                    if (r >= int'(clr_row))
                        board_nxt[r*BOARD_W +: BOARD_W] = board_q[(r+1)*BOARD_W +: BOARD_W];
                end
                board_nxt[(BOARD_H_EXT-1)*BOARD_W +: BOARD_W] = '0;
            end
            st_fail, st_over: board_nxt = '0;
            default: board_nxt = board_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            board_q <= '0;
        else
            board_q <= board_nxt;
    end

    // flags from the board held after this edge
    always_comb begin
        for (int r = 0; r < BOARD_H; r++)
            full_nxt[r] = &board_nxt[r*BOARD_W +: BOARD_W];
    end

    assign row_full_any = |full_nxt;
    assign overflow     = |board_nxt[BOARD_H_EXT*BOARD_W-1 : BOARD_H*BOARD_W];

    assign board_ext = board_q;
    assign board_vis = board_q[BOARD_H*BOARD_W-1:0];

endmodule

`default_nettype wire

// File: src/drop_solver.sv
// --------------------------------------------------------------------------
// landing row solver in two steps
// accept edge registers shape, column and four candidate rows
// landing row is then the largest registered candidate
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module drop_solver import tetris_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     accept,
    input  shape_t   tetrominoes,
    input  col_t     position,
    input  heights_t heights,
    output row_t     land_row,
    output shape_t   shape_q,
    output col_t     col_q
);

    // heights of the four columns from position rightward
    row_t [3:0] h_win;
    row_t [3:0] cand;
    row_t [3:0] cand_q;
    row_t       max_lo;
    row_t       max_hi;
    row_t       max_all;

    // columns past the right edge read as zero
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            h_win[k] = '0;
            for (int c = 0; c < BOARD_W; c++) begin
                if (c == int'(position) + k)
                    h_win[k] = heights[c];
            end
        end
    end

    // ----------------------------------------------------------------------
    // candidate rows, height plus overhang of the shape
    // unused slots stay zero
    // ----------------------------------------------------------------------
    always_comb begin
        cand = '0;
        case (tetrominoes)
            SHAPE_SQUARE, SHAPE_L_UP: begin
                cand[0] = h_win[0];
                cand[1] = h_win[1];
            end
            SHAPE_BAR_V: cand[0] = h_win[0];
            SHAPE_BAR_H: cand = h_win;
            // right leg hangs two rows below the corner
            SHAPE_J_UP: begin
                cand[0] = h_win[0];
                cand[1] = h_win[1] + 4'd2;
            end
            SHAPE_S_V: begin
                cand[0] = h_win[0];
                cand[1] = h_win[1] + 4'd1;
            end
            // flat shapes, candidates counted from the upper row
            SHAPE_L_FLAT: begin
                cand[0] = h_win[0] + 4'd1;
                cand[1] = h_win[1];
                cand[2] = h_win[2];
            end
            SHAPE_Z_FLAT: begin
                cand[0] = h_win[0] + 4'd1;
                cand[1] = h_win[1] + 4'd1;
                cand[2] = h_win[2];
            end
            default: cand = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_q  <= '0;
            shape_q <= '0;
            col_q   <= '0;
        end else if (accept) begin
            cand_q  <= cand;
            shape_q <= tetrominoes;
            col_q   <= position;
        end
    end

    // max over the four registered candidates
    assign max_lo  = (cand_q[0] > cand_q[1]) ? cand_q[0] : cand_q[1];
    assign max_hi  = (cand_q[2] > cand_q[3]) ? cand_q[2] : cand_q[3];
    assign max_all = (max_lo > max_hi) ? max_lo : max_hi;

    // upper-row candidates of the flat shapes always win, step back one row
    assign land_row = (shape_q == SHAPE_L_FLAT || shape_q == SHAPE_Z_FLAT) ?
                      max_all - 4'd1 : max_all;

endmodule

`default_nettype wire

// File: src/column_height.sv
// --------------------------------------------------------------------------
// column heights of the visible board
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module column_height import tetris_pkg::*; (
    input  ext_board_t board_ext,
    output heights_t   heights
);

    // height is one above the highest filled visible cell
    // empty column gives zero
    always_comb begin
        for (int c = 0; c < BOARD_W; c++) begin
            heights[c] = '0;
            // scan upward so the top cell wins
            for (int r = 0; r < BOARD_H; r++) begin
                if (board_ext[r*BOARD_W + c])
                    heights[c] = row_t'(r + 1);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/game_ctrl.sv
// --------------------------------------------------------------------------
// game FSM with piece counter and score register
// drives the accept strobe, the phase and the result outputs
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module game_ctrl import tetris_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic        row_full_any,
    input  logic        overflow,
    input  board_t      board_vis,
    output logic        accept,
    output game_state_t phase,
    output logic        score_valid,
    output logic        tetris_valid,
    output logic        fail,
    output score_t      score,
    output board_t      tetris
);

    game_state_t state_q;
    game_state_t state_nxt;
    count_t      count_q;
    score_t      score_q;

    // pieces only enter while idle
    assign accept = (state_q == st_idle) && in_valid;
    assign phase  = state_q;

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            st_idle: begin
                if (accept) state_nxt = st_place;
            end
            // flags look at the board after this cycle's update
            st_place, st_clear: begin
                if (row_full_any)
                    state_nxt = st_clear;
                else if (overflow)
                    state_nxt = st_fail;
                else if (count_q == PIECES_PER_GAME)
                    state_nxt = st_over;
                else
                    state_nxt = st_report;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            count_q <= '0;
            score_q <= '0;
        end else begin
            state_q <= state_nxt;
            // count on accept, new game after either ending
            if (state_q == st_fail || state_q == st_over)
                count_q <= '0;
            else if (accept)
                count_q <= count_q + 5'd1;
            // one point per removed row
            if (state_q == st_fail || state_q == st_over)
                score_q <= '0;
            else if (state_q == st_clear)
                score_q <= score_q + 4'd1;
        end
    end

    // ----------------------------------------------------------------------
    // result outputs, zero outside the result cycle
    // ----------------------------------------------------------------------
    assign score_valid  = (state_q == st_report) || (state_q == st_fail) ||
                          (state_q == st_over);
    assign fail         = (state_q == st_fail);
    assign tetris_valid = (state_q == st_fail) || (state_q == st_over);
    assign score        = score_valid ? score_q : '0;
    // board only shown when the game ends
    assign tetris       = tetris_valid ? board_vis : '0;

endmodule

`default_nettype wire

// File: src/tetris_pkg.sv
// --------------------------------------------------------------------------
// shared definitions of the stacking game engine
// board sizes, piece count per game, shape codes
// payload types and the FSM state encoding
// --------------------------------------------------------------------------
`default_nettype none

package tetris_pkg;

    // board geometry
    localparam int BOARD_W     = 6;
    localparam int BOARD_H     = 12;
    // four spare rows above the visible board catch pieces that stick out
    localparam int BOARD_H_EXT = 16;

    typedef logic [2:0] shape_t;
    typedef logic [2:0] col_t;
    // row index, also used for column heights
    typedef logic [3:0] row_t;
    typedef logic [3:0] score_t;
    typedef logic [4:0] count_t;

    // cell (r, c) sits at bit 6*r + c, row 0 at the bottom
    typedef logic [BOARD_W*BOARD_H-1:0]     board_t;
    typedef logic [BOARD_W*BOARD_H_EXT-1:0] ext_board_t;
    typedef row_t [BOARD_W-1:0]             heights_t;

    localparam count_t PIECES_PER_GAME = 5'd16;

    // shape codes
    localparam shape_t SHAPE_SQUARE = 3'd0;
    localparam shape_t SHAPE_BAR_V  = 3'd1;
    localparam shape_t SHAPE_BAR_H  = 3'd2;
    localparam shape_t SHAPE_J_UP   = 3'd3;
    localparam shape_t SHAPE_L_FLAT = 3'd4;
    localparam shape_t SHAPE_L_UP   = 3'd5;
    localparam shape_t SHAPE_S_V    = 3'd6;
    localparam shape_t SHAPE_Z_FLAT = 3'd7;

    // FSM states, result states share bit 0
    typedef enum logic [2:0] {
        st_idle   = 3'b000,
        st_place  = 3'b001,
        st_clear  = 3'b100,
        st_report = 3'b011,
        st_fail   = 3'b101,
        st_over   = 3'b111
    } game_state_t;

endpackage

`default_nettype wire
